//--- src.f
+incdir+hw
+incdir+test
hw/craPkg.sv
hw/cramStore.sv
hw/dispatchMux.sv
hw/sbrStack.sv
hw/craAddress.sv
hw/diagAxiLite.sv
hw/microSeq.sv
test/microSeqTb.sv

//--- test/tbAxiTasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

//////////////////////////////////////////////////
// AXI4-Lite master side

// With bready held high B completes on the first edge with bvalid
task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
  @(posedge CLK);
  awaddr  <= addr;
  wdata   <= data;
  awvalid <= 1'b1;
  wvalid  <= 1'b1;
  // AW and W go in together
  @(posedge CLK);
  while (!(awready && wready)) @(posedge CLK);
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  @(posedge CLK);
  while (!bvalid) @(posedge CLK);
  assert (bresp == `AXI_RESP_OKAY) else valueError("bresp", bresp, `AXI_RESP_OKAY);
endtask

// With rready held high the data is taken on the first edge with rvalid
task automatic readReg(input logic [4:0] addr, output logic [31:0] data);
  @(posedge CLK);
  araddr  <= addr;
  arvalid <= 1'b1;
  @(posedge CLK);
  while (!arready) @(posedge CLK);
  arvalid <= 1'b0;
  @(posedge CLK);
  while (!rvalid) @(posedge CLK);
  data = rdata;
  assert (rresp == `AXI_RESP_OKAY) else valueError("rresp", rresp, `AXI_RESP_OKAY);
endtask

//////////////////////////////////////////////////
// Program generation

// J stays in the low 256 words so every jump lands on a loaded word
// CALL is set 7 times in 8 so the stack overflows now and then
function automatic craPkg::cramWordT randomWord();
  integer r;
  craPkg::dispT code;
  r = $random(seed);
  case (r[10:8])
    3'd0:    code = `DISP_NONE;
    3'd1:    code = `DISP_DRAM;
    3'd2:    code = `DISP_DIAG;
    3'd3:    code = `DISP_RET;
    3'd4:    code = `DISP_NIB;
    3'd5:    code = `DISP_SKIP;
    // An unused code that contributes nothing
    3'd6:    code = 5'd5;
    default: code = `DISP_NONE;
  endcase
  return {3'b000, r[7:0], code, (r[13:11] != 3'd0), r[16:14]};
endfunction

`endif

//--- test/microSeqTb.sv
`include "cra_defines.svh"

module microSeqTb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int PROG_WORDS = 256;
  localparam int RUN_CYCLES = 1000;
  localparam int SEGMENTS   = 10;
  // Load at about 4 cycles per write, the run cycles, then margin
  localparam int MAX_CYCLES = 4000;
  // The force target at 1777 calls back into the program at 0
  localparam logic [31:0] FORCE_WORD = 32'h00008;

  logic CLK = 1'b0;
  logic rst;
  logic [4:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] wdata, rdata;
  logic [1:0] bresp, rresp;
  logic force1777;
  craPkg::cramAdrT dramJ;
  logic [3:0] dispNibble;
  logic [7:0] condIn;
  craPkg::cramAdrT cradr;
  craPkg::cramWordT cramWord;
  logic dispParity;

  integer seed = 22162;
  int cycleCount = 0;

  // Reference model state
  craPkg::cramWordT progList [PROG_WORDS];
  craPkg::cramAdrT diagList [SEGMENTS];
  craPkg::cramWordT progMem [`CRA_DEPTH];
  craPkg::cramAdrT retStack [`CRA_STACK_DEPTH];
  logic [`CRA_STACK_DEPTH-1:0] stackValid;
  craPkg::cramAdrT mCradr, mDiag, mLoad;
  craPkg::cramWordT mWord;
  craPkg::stackPtrT mPtr;
  logic mRun;
  int stepCount, returnCount, wrapCount, diagCount;

  microSeq dut (
    .CLK (CLK), .rst (rst),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .force1777 (force1777), .dramJ (dramJ), .dispNibble (dispNibble),
    .condIn (condIn), .cradr (cradr), .cramWord (cramWord), .dispParity (dispParity)
  );

  always #20 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Failure reporting

  task automatic abortRun(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic valueError(input string name, input logic [31:0] got, input logic [31:0] exp);
    abortRun($sformatf("Error: time %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  `include "tbAxiTasks.svh"

  // XOR of CALL and DISP
  function automatic logic parityOf(input craPkg::cramWordT w);
    return ^{w[`CRA_CALL_BIT], w[`CRA_DISP_HI:`CRA_DISP_LO]};
  endfunction

  // Status holds cradr in 10..0, the pointer in 19..16 and parity in 24
  function automatic logic [31:0] statusOf();
    logic [31:0] s;
    s = '0;
    s[10:0] = mCradr;
    s[19:16] = mPtr;
    s[24] = parityOf(mWord);
    return s;
  endfunction

  //////////////////////////////////////////////////
  // Reference model and sideband stimulus

  always @(posedge CLK) begin : refModel
    craPkg::cramAdrT contrib;
    craPkg::cramAdrT nxt;
    craPkg::dispT code;
    integer r;
    if (rst) begin
      mCradr = '0;
      mWord = '0;
      mPtr = '0;
      mRun = 1'b0;
      mDiag = '0;
      mLoad = '0;
      stackValid = '0;
    end else begin
      // One sequencer step with the inputs seen on this edge
      if (mRun) begin
        code = mWord[`CRA_DISP_HI:`CRA_DISP_LO];
        case (code)
          `DISP_DRAM: contrib = dramJ;
          `DISP_DIAG: contrib = mDiag;
          `DISP_RET:  contrib = retStack[mPtr];
          `DISP_NIB:  contrib = {7'b0, dispNibble};
          `DISP_SKIP: contrib = {10'b0, condIn[mWord[`CRA_COND_HI:`CRA_COND_LO]]};
          default:    contrib = '0;
        endcase
        nxt = mWord[`CRA_J_HI:`CRA_J_LO] | contrib | {`CRA_ADR_W{force1777}};
        if (force1777) begin
          mPtr = '0;
        end else if (code == `DISP_RET) begin
          mPtr = mPtr - 1'b1;
          returnCount++;
        end else if (mWord[`CRA_CALL_BIT]) begin
          // Push past 16 wraps onto the oldest entry
          if (mPtr == 4'd15) wrapCount++;
          mPtr = mPtr + 1'b1;
          retStack[mPtr] = mCradr;
          stackValid[mPtr] = 1'b1;
        end
        if (code == `DISP_DIAG && !force1777) diagCount++;
        mCradr = nxt;
        mWord = progMem[nxt];
        stepCount++;
      end
      // Register writes seen on the bus
      if (awvalid && awready && wvalid) begin
        case (awaddr)
          `REG_DIAGADR:  mDiag = wdata[`CRA_ADR_W-1:0];
          `REG_LOADADR:  mLoad = wdata[`CRA_ADR_W-1:0];
          `REG_LOADDATA: begin
            progMem[mLoad] = wdata[`CRA_WORD_W-1:0];
            mLoad = mLoad + 1'b1;
          end
          `REG_CTRL:     mRun = wdata[0];
          default:       ;
        endcase
      end
    end
    // Fresh sideband values for the next cycle
    r = $random(seed);
    dramJ <= {3'b000, r[7:0]};
    dispNibble <= r[11:8];
    condIn <= r[19:12];
    // Force now and then and always before a return into an unwritten entry
    force1777 <= (r[25:20] == 6'd0) ||
                 (mWord[`CRA_DISP_HI:`CRA_DISP_LO] == `DISP_RET && !stackValid[mPtr]);
  end

  //////////////////////////////////////////////////
  // Per-cycle checks sampled mid-cycle

  always @(negedge CLK) begin
    if (!rst) begin
      assert (cradr === mCradr) else valueError("cradr", cradr, mCradr);
      assert (cramWord === mWord) else valueError("cramWord", cramWord, mWord);
      assert (dispParity === parityOf(mWord))
        else valueError("dispParity", dispParity, parityOf(mWord));
    end
  end

  always @(posedge CLK) begin
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
      abortRun($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  //////////////////////////////////////////////////
  // Test sequence

  initial begin : mainSeq
    logic [31:0] data;
    craPkg::cramAdrT frozen;
    integer r;
    int target;
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    force1777 = 1'b0;
    dramJ = '0;
    dispNibble = '0;
    condIn = '0;
    stepCount = 0;
    returnCount = 0;
    wrapCount = 0;
    diagCount = 0;
    // All random program data is drawn before the clock starts
    for (int i = 0; i < PROG_WORDS; i++) progList[i] = randomWord();
    for (int i = 0; i < SEGMENTS; i++) begin
      r = $random(seed);
      diagList[i] = {3'b000, r[7:0]};
    end
    repeat (3) @(posedge CLK);
    rst <= 1'b0;

    // State right after reset
    @(negedge CLK);
    assert (cradr === '0) else valueError("cradr", cradr, 0);
    // Every AXI ready and valid output starts low
    assert ({awready, wready, arready, bvalid, rvalid} === 5'b0)
      else valueError("awready wready arready bvalid rvalid",
                      {awready, wready, arready, bvalid, rvalid}, 0);
    readReg(`REG_STATUS, data);
    assert (data === 32'h0) else valueError("status", data, 32'h0);

    // Program load followed by the force target at 1777
    writeReg(`REG_LOADADR, 32'h0);
    for (int i = 0; i < PROG_WORDS; i++) writeReg(`REG_LOADDATA, {12'h0, progList[i]});
    writeReg(`REG_LOADADR, 32'h7FF);
    writeReg(`REG_LOADDATA, FORCE_WORD);
    readReg(`REG_STATUS, data);
    assert (data === statusOf()) else valueError("status", data, statusOf());
    assert (cradr === '0) else valueError("cradr", cradr, 0);

    // Run in segments that each get a new DIAG address and a stop
    for (int seg = 0; seg < SEGMENTS; seg++) begin
      writeReg(`REG_DIAGADR, {21'h0, diagList[seg]});
      writeReg(`REG_CTRL, 32'h1);
      target = stepCount + RUN_CYCLES / SEGMENTS;
      while (stepCount < target) @(negedge CLK);
      writeReg(`REG_CTRL, 32'h0);
      readReg(`REG_STATUS, data);
      assert (data === statusOf()) else valueError("status", data, statusOf());
      @(negedge CLK);
      frozen = cradr;
      repeat (4) @(negedge CLK);
      assert (cradr === frozen) else valueError("cradr while stopped", cradr, frozen);
    end

    assert (returnCount > 0) else abortRun("No subroutine return was taken during the run");
    assert (wrapCount > 0) else abortRun("The return stack never wrapped past 16 entries");
    assert (diagCount > 0) else abortRun("No DIAG dispatch was taken during the run");
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- hw/microSeq.sv
module microSeq (
  input  logic              CLK,
  input  logic              rst,
  // Diagnostic AXI4-Lite slave
  input  logic [4:0]        awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [4:0]        araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  // Sideband from the rest of the machine
  input  logic              force1777,
  input  craPkg::cramAdrT   dramJ,
  input  logic [3:0]        dispNibble,
  input  logic [7:0]        condIn,
  output craPkg::cramAdrT   cradr,
  output craPkg::cramWordT  cramWord,
  output logic              dispParity
);

  logic              run;
  craPkg::cramAdrT   diagAdr;
  logic              cramWrEn;
  craPkg::cramAdrT   cramWrAdr;
  craPkg::cramWordT  cramWrData;
  craPkg::cramAdrT   nextAdr;
  craPkg::stackPtrT  stackPtr;

  // Diagnostic register slave
  diagAxiLite uDiag (
    .CLK (CLK), .rst (rst),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .run (run), .diagAdr (diagAdr),
    .cramWrEn (cramWrEn), .cramWrAdr (cramWrAdr), .cramWrData (cramWrData),
    .cradr (cradr), .stackPtr (stackPtr), .dispParity (dispParity)
  );

  // Next address, CRADR and the return stack
  craAddress uAdr (
    .CLK (CLK), .rst (rst), .run (run), .force1777 (force1777),
    .word (cramWord), .dramJ (dramJ), .diagAdr (diagAdr),
    .dispNibble (dispNibble), .condIn (condIn),
    .nextAdr (nextAdr), .cradr (cradr), .stackPtr (stackPtr),
    .dispParity (dispParity)
  );

  // Store word freezes with CRADR when stopped
  cramStore uStore (
    .CLK (CLK), .rst (rst), .rdAdr (nextAdr),
    .wrEn (cramWrEn), .wrAdr (cramWrAdr), .wrData (cramWrData),
    .hold (~run), .word (cramWord)
  );

endmodule

//--- hw/diagAxiLite.sv
`include "cra_defines.svh"

module diagAxiLite (
  input  logic                       CLK,
  input  logic                       rst,
  // Write address and data
  input  logic [`CRA_AXI_ADR_W-1:0]  awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [`CRA_AXI_DATA_W-1:0] wdata,
  input  logic                       wvalid,
  output logic                       wready,
  // Write response
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  logic                       bready,
  // Read address and data
  input  logic [`CRA_AXI_ADR_W-1:0]  araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [`CRA_AXI_DATA_W-1:0] rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready,
  // Sequencer control
  output logic                       run,
  output craPkg::cramAdrT            diagAdr,
  // Store load port
  output logic                       cramWrEn,
  output craPkg::cramAdrT            cramWrAdr,
  output craPkg::cramWordT           cramWrData,
  // Status
  input  craPkg::cramAdrT            cradr,
  input  craPkg::stackPtrT           stackPtr,
  input  logic                       dispParity
);

  craPkg::axiWrStateT          wrState;
  craPkg::axiRdStateT          rdState;
  logic                        wrReady;
  logic                        wrFire;
  craPkg::cramAdrT             loadAdr;
  logic [`CRA_AXI_DATA_W-1:0]  rdMux;

  //////////////////////////////////////////////////
  // Write channels

  // AW and W are taken on the same edge
  assign awready = wrReady;
  assign wready  = wrReady;
  assign wrFire  = wrReady & awvalid & wvalid;
  assign bvalid  = (wrState == craPkg::WR_RESP);
  assign bresp   = `AXI_RESP_OKAY;

  always_ff @(posedge CLK) begin
    if (rst) begin
      wrState <= craPkg::WR_IDLE;
      wrReady <= 1'b0;
      run     <= 1'b0;
      diagAdr <= '0;
      loadAdr <= '0;
    end else begin
      case (wrState)
        craPkg::WR_IDLE: begin
          wrReady <= ~wrFire;
          if (wrFire) begin
            wrState <= craPkg::WR_RESP;
            case (awaddr)
              `REG_DIAGADR:  diagAdr <= wdata[`CRA_ADR_W-1:0];
              `REG_LOADADR:  loadAdr <= wdata[`CRA_ADR_W-1:0];
              // Store write happens on this edge, step to the next word
              `REG_LOADDATA: loadAdr <= loadAdr + 1'b1;
              `REG_CTRL:     run     <= wdata[0];
              default:       ;
            endcase
          end
        end
        // Hold B until the master takes it
        craPkg::WR_RESP: begin
          if (bready) begin
            wrState <= craPkg::WR_IDLE;
            wrReady <= 1'b1;
          end
        end
        default: wrState <= craPkg::WR_IDLE;
      endcase
    end
  end

  // Load data goes straight to the store at the load address
  assign cramWrEn   = wrFire && (awaddr == `REG_LOADDATA);
  assign cramWrAdr  = loadAdr;
  assign cramWrData = wdata[`CRA_WORD_W-1:0];

  //////////////////////////////////////////////////
  // Read channel

  // Status packs CRADR, pointer and parity
  always_comb begin
    rdMux = '0;
    case (araddr)
      `REG_DIAGADR: rdMux[`CRA_ADR_W-1:0] = diagAdr;
      `REG_LOADADR: rdMux[`CRA_ADR_W-1:0] = loadAdr;
      `REG_CTRL:    rdMux[0] = run;
      `REG_STATUS: begin
        rdMux[`CRA_ADR_W-1:0]        = cradr;
        rdMux[16 +: `CRA_STACK_PTR_W] = stackPtr;
        rdMux[24]                    = dispParity;
      end
      default:      rdMux = '0;
    endcase
  end

  assign rvalid = (rdState == craPkg::RD_DATA);
  assign rresp  = `AXI_RESP_OKAY;

  always_ff @(posedge CLK) begin
    if (rst) begin
      rdState <= craPkg::RD_IDLE;
      arready <= 1'b0;
      rdata   <= '0;
    end else if (rdState == craPkg::RD_IDLE) begin
      arready <= 1'b1;
      if (arready && arvalid) begin
        arready <= 1'b0;
        rdata   <= rdMux;
        rdState <= craPkg::RD_DATA;
      end
    end else if (rready) begin
      // R taken, ready for the next address
      rdState <= craPkg::RD_IDLE;
      arready <= 1'b1;
    end
  end

endmodule

//--- hw/craAddress.sv
`include "cra_defines.svh"

module craAddress (
  input  logic              CLK,
  input  logic              rst,
  input  logic              run,
  input  logic              force1777,
  // Current microword
  input  craPkg::cramWordT  word,
  // Dispatch sources
  input  craPkg::cramAdrT   dramJ,
  input  craPkg::cramAdrT   diagAdr,
  input  logic [3:0]        dispNibble,
  input  logic [7:0]        condIn,
  // To the store read port
  output craPkg::cramAdrT   nextAdr,
  output craPkg::cramAdrT   cradr,
  output craPkg::stackPtrT  stackPtr,
  output logic              dispParity
);

  craPkg::cramAdrT jField;
  craPkg::cramAdrT dispatch;
  craPkg::cramAdrT sbrRet;
  craPkg::dispT    disp;
  logic            isRet;
  logic            isCall;

  assign jField = word[`CRA_J_HI:`CRA_J_LO];
  assign disp   = word[`CRA_DISP_HI:`CRA_DISP_LO];

  // DISP and COND decoding
  dispatchMux uMux (
    .word       (word),
    .dramJ      (dramJ),
    .diagAdr    (diagAdr),
    .sbrRet     (sbrRet),
    .dispNibble (dispNibble),
    .condIn     (condIn),
    .dispatch   (dispatch),
    .isRet      (isRet),
    .isCall     (isCall)
  );

  // Call saves CRADR, force 1777 resets the pointer
  sbrStack uStack (
    .CLK     (CLK),     .rst (rst),
    .step    (run),     .clear (force1777),
    .push    (isCall),  .pop (isRet),
    .pushAdr (cradr),   .sbrRet (sbrRet),
    .ptr     (stackPtr)
  );

  //////////////////////////////////////////////////
  // Next address

  // Wired OR of J, dispatch and the force
  assign nextAdr = jField | dispatch | {`CRA_ADR_W{force1777}};

  always_ff @(posedge CLK) begin
    if (rst) begin
      cradr <= '0;
    end else if (run) begin
      cradr <= nextAdr;
    end
  end

  // Parity over CALL and DISP, for diagnostics
  assign dispParity = ^{word[`CRA_CALL_BIT], disp};

endmodule

//--- hw/sbrStack.sv
`include "cra_defines.svh"

module sbrStack (
  input  logic              CLK,
  input  logic              rst,
  // Sequencer step, the stack moves only on these cycles
  input  logic              step,
  // Force 1777 resets the pointer
  input  logic              clear,
  input  logic              push,
  input  logic              pop,
  // Address saved by a call
  input  craPkg::cramAdrT   pushAdr,
  // Top entry, read without a clock
  output craPkg::cramAdrT   sbrRet,
  output craPkg::stackPtrT  ptr
);

  // Return address storage
  craPkg::cramAdrT  stackMem [`CRA_STACK_DEPTH];

  // Pointer after a push, also the write slot
  craPkg::stackPtrT ptrInc;
  craPkg::stackPtrT ptrDec;

  assign ptrInc = ptr + 1'b1;
  assign ptrDec = ptr - 1'b1;

  //////////////////////////////////////////////////
  // Pointer

  // Binary up/down counter, wraps modulo the depth
  // Clear beats push and pop
  always_ff @(posedge CLK) begin
    if (rst) begin
      ptr <= '0;
    end else if (step) begin
      if (clear) begin
        ptr <= '0;
      end else if (push) begin
        ptr <= ptrInc;
      end else if (pop) begin
        // Entry was read this cycle, drop it now
        ptr <= ptrDec;
      end
    end
  end

  //////////////////////////////////////////////////
  // Storage

  // Push writes at the new pointer
  // deeper than 16 overwrites the oldest entry
  always_ff @(posedge CLK) begin
    if (step && !clear && push) begin
      stackMem[ptrInc] <= pushAdr;
    end
  end

  // Return address is the entry under the pointer
  assign sbrRet = stackMem[ptr];

endmodule

//--- hw/dispatchMux.sv
`include "cra_defines.svh"

module dispatchMux (
  input  craPkg::cramWordT word,
  // Dispatch sources
  input  craPkg::cramAdrT  dramJ,
  input  craPkg::cramAdrT  diagAdr,
  input  craPkg::cramAdrT  sbrRet,
  input  logic [3:0]       dispNibble,
  input  logic [7:0]       condIn,
  // Contribution ORed into the next address
  output craPkg::cramAdrT  dispatch,
  // Stack strobes
  output logic             isRet,
  output logic             isCall
);

  craPkg::dispT    disp;
  craPkg::condSelT cond;
  logic            callBit;
  logic            skipBit;

  //////////////////////////////////////////////////
  // Microword fields

  assign disp    = word[`CRA_DISP_HI:`CRA_DISP_LO];
  assign cond    = word[`CRA_COND_HI:`CRA_COND_LO];
  assign callBit = word[`CRA_CALL_BIT];

  // Single skip multiplexer, eight conditions
  assign skipBit = condIn[cond];

  //////////////////////////////////////////////////
  // Dispatch select

  always_comb begin
    case (disp)
      // No dispatch, J alone
      `DISP_NONE: dispatch = '0;
      // Instruction decode jump
      `DISP_DRAM: dispatch = dramJ;
      // Address set over the diagnostic slave
      `DISP_DIAG: dispatch = diagAdr;
      // Subroutine return
      `DISP_RET:  dispatch = sbrRet;
      // 16-way branch on the low bits
      `DISP_NIB:  dispatch = {{(`CRA_ADR_W-4){1'b0}}, dispNibble};
      // 2-way skip into bit 0
      `DISP_SKIP: dispatch = {{(`CRA_ADR_W-1){1'b0}}, skipBit};
      // Unused codes contribute nothing
      default:    dispatch = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Stack strobes

  // Return pops
  assign isRet = (disp == `DISP_RET);

  // A return wins over CALL in the same word
  assign isCall = callBit & ~isRet;

endmodule

//--- hw/cramStore.sv
`include "cra_defines.svh"

module cramStore (
  input  logic              CLK,
  input  logic              rst,
  // Sequencer side read
  input  craPkg::cramAdrT   rdAdr,
  // Diagnostic load port
  input  logic              wrEn,
  input  craPkg::cramAdrT   wrAdr,
  input  craPkg::cramWordT  wrData,
  // Freeze the output word while sequencing is stopped
  input  logic              hold,
  output craPkg::cramWordT  word
);

  // The 2K control store itself
  craPkg::cramWordT mem [`CRA_DEPTH];

  //////////////////////////////////////////////////
  // Load port

  // Plain synchronous write
  // A write at the word being read shows only on a later read
  always_ff @(posedge CLK) begin
    if (wrEn) begin
      mem[wrAdr] <= wrData;
    end
  end

  //////////////////////////////////////////////////
  // Read register

  // Loads the same address that CRADR loads on this edge
  // so the word out always belongs to the current CRADR
  always_ff @(posedge CLK) begin
    if (rst) begin
      // Matches CRADR = 0 of a cleared store
      word <= '0;
    end else if (!hold) begin
      word <= mem[rdAdr];
    end
  end

  // Hold keeps the last word, so a stopped sequencer shows
  // the word it stopped on
  // the read register just keeps its value

endmodule

//--- hw/craPkg.sv
`include "cra_defines.svh"

package craPkg;

  //////////////////////////////////////////////////
  // Vector types

  // Microaddress, CRADR and every dispatch source
  typedef logic [`CRA_ADR_W-1:0] cramAdrT;

  // One control store word
  // J 19..9, DISP 8..4, CALL 3, COND 2..0
  typedef logic [`CRA_WORD_W-1:0] cramWordT;

  // DISP field alone
  typedef logic [`CRA_DISP_HI-`CRA_DISP_LO:0] dispT;

  // Skip condition select
  typedef logic [`CRA_COND_HI-`CRA_COND_LO:0] condSelT;

  // Return stack pointer, wraps at the stack depth
  typedef logic [`CRA_STACK_PTR_W-1:0] stackPtrT;

  //////////////////////////////////////////////////
  // Diagnostic slave channel machines

  // Write side waits in IDLE for AW and W together, then holds B
  typedef enum logic {WR_IDLE, WR_RESP} axiWrStateT;

  // Read side waits in IDLE for AR, then holds R
  typedef enum logic {RD_IDLE, RD_DATA} axiRdStateT;

endpackage

//--- hw/cra_defines.svh
`ifndef CRA_DEFINES_SVH
`define CRA_DEFINES_SVH

// Control store geometry
`define CRA_ADR_W        11
`define CRA_DEPTH        2048
`define CRA_WORD_W       20

// Return stack geometry
`define CRA_STACK_DEPTH  16
`define CRA_STACK_PTR_W  4

// Microword field positions
`define CRA_J_HI         19
`define CRA_J_LO         9
`define CRA_DISP_HI      8
`define CRA_DISP_LO      4
`define CRA_CALL_BIT     3
`define CRA_COND_HI      2
`define CRA_COND_LO      0

// DISP field codes
`define DISP_NONE        5'd0
`define DISP_DRAM        5'd1
`define DISP_DIAG        5'd2
`define DISP_RET         5'd3
`define DISP_NIB         5'd7
`define DISP_SKIP        5'd8

// Diagnostic slave geometry and register map
`define CRA_AXI_ADR_W    5
`define CRA_AXI_DATA_W   32
`define AXI_RESP_OKAY    2'b00
`define REG_DIAGADR      5'h00
`define REG_LOADADR      5'h04
`define REG_LOADDATA     5'h08
`define REG_CTRL         5'h0C
`define REG_STATUS       5'h10

`endif
